//--- design/tlu_pkg.sv
package tlu_pkg;

    localparam int clk_divisor        = 8;   // TRIGGER_CLK cycles per TLU serial bit
    localparam int data_width         = 32;
    localparam int sr_width           = data_width * clk_divisor;
    localparam int glitch_wait_cycles = 5;   // short scintillator pulses glitch the trigger line
    localparam int sync_delay_cycles  = 3;   // minimum latch delay for sync

    // same encodings as the register map, 2'b01 behaves like no handshake
    typedef enum logic [1:0] {
        mode_no_handshake     = 2'b00,
        mode_simple_handshake = 2'b10,
        mode_data_handshake   = 2'b11
    } tlu_mode_e;

    typedef enum logic [2:0] {
        st_idle              = 3'b000,
        st_wait_trigger_low  = 3'b001,
        st_send_tlu_clock    = 3'b010,
        st_wait_before_latch = 3'b011,
        st_latch_data        = 3'b100,
        st_wait_ack          = 3'b101
    } tlu_state_e;

    typedef struct packed {
        tlu_mode_e  mode;
        logic [7:0] low_timeout;   // 0 disables the timeout
        logic [4:0] clock_cycles;  // 0 means 32
        logic [3:0] data_delay;
        logic       msb_first;
        logic       disable_veto;
    } tlu_config_t;

    typedef struct packed {
        logic busy;
        logic clock_enable;
        logic assert_veto;
        logic low_timeout_error;
        logic accept_error;
    } tlu_status_t;

    typedef struct packed {
        logic                  marker;   // always set
        logic [data_width-2:0] payload;
    } fifo_word_t;

endpackage

//--- design/tlu_trigger_fsm.sv
`timescale 1ns/100ps

module tlu_trigger_fsm (
    input  logic                 TRIGGER_CLK,
    input  logic                 rst_n,
    input  logic                 trigger,
    input  logic                 trigger_flag,
    input  logic                 trigger_veto,
    input  logic                 trigger_enable,
    input  logic                 trigger_ack,
    input  tlu_pkg::tlu_config_t cfg,
    output logic                 accept_pulse,
    output logic                 latch_pulse,
    output tlu_pkg::tlu_status_t status
);
    import tlu_pkg::*;

    tlu_state_e state;
    tlu_state_e next;

    logic [7:0] low_cnt;       // cycles spent waiting for trigger low
    logic [8:0] tlu_clk_cnt;
    logic [4:0] wait_cnt;
    logic       acknowledged;  // ack seen since acceptance
    logic       handshake;
    logic       low_done;
    logic [5:0] clock_len;
    logic [8:0] clk_target;
    logic [4:0] wait_target;

    assign handshake = (cfg.mode == mode_simple_handshake) || (cfg.mode == mode_data_handshake);
    assign clock_len = (cfg.clock_cycles == 5'd0) ? 6'd32 : {1'b0, cfg.clock_cycles};
    assign clk_target = 9'(clock_len * clk_divisor);
    assign wait_target = 5'(cfg.data_delay + sync_delay_cycles);

    // trigger low is only trusted after the glitch window
    assign low_done = (low_cnt >= 8'(glitch_wait_cycles))
                      && (!trigger || status.low_timeout_error);

    always_comb
    begin
        next = state;
        case (state)
            st_idle:
            begin
                if (!trigger_ack && trigger_enable
                    && (trigger_flag || (handshake && trigger))
                    && (!trigger_veto || handshake))
                    next = st_wait_trigger_low;
            end
            st_wait_trigger_low:
            begin
                if (!handshake)
                    next = st_latch_data;  // no need to wait for trigger low
                else if (low_done)
                    next = (cfg.mode == mode_data_handshake) ? st_send_tlu_clock : st_latch_data;
            end
            st_send_tlu_clock:
            begin
                if (tlu_clk_cnt == clk_target)
                    next = st_wait_before_latch;
            end
            st_wait_before_latch:
            begin
                if (wait_cnt == wait_target)
                    next = st_latch_data;
            end
            st_latch_data:
                next = st_wait_ack;
            st_wait_ack:
            begin
                if (trigger_ack || acknowledged)
                    next = st_idle;
            end
            default:
                next = st_idle;
        endcase
    end

    always_ff @(posedge TRIGGER_CLK or negedge rst_n)
    begin
        if (!rst_n)
            state <= st_idle;
        else
            state <= next;
    end

    // outputs are registered from next, so they line up with the state
    always_ff @(posedge TRIGGER_CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            low_cnt      <= '0;
            tlu_clk_cnt  <= '0;
            wait_cnt     <= '0;
            acknowledged <= 1'b0;
            accept_pulse <= 1'b0;
            latch_pulse  <= 1'b0;
            status       <= '0;
        end
        else
        begin
            accept_pulse        <= (next == st_wait_trigger_low) && (state != st_wait_trigger_low);
            latch_pulse         <= (next == st_latch_data);
            status.busy         <= (next != st_idle);  // drops with the return to idle
            status.clock_enable <= (next == st_send_tlu_clock);

            if (next == st_wait_trigger_low)
            begin
                if (low_cnt != 8'hff)
                    low_cnt <= low_cnt + 8'd1;  // saturates
                if (cfg.low_timeout != 8'd0 && low_cnt >= cfg.low_timeout)
                    status.low_timeout_error <= 1'b1;
            end
            else
                low_cnt <= '0;

            tlu_clk_cnt <= (next == st_send_tlu_clock) ? tlu_clk_cnt + 9'd1 : 9'd0;
            wait_cnt    <= (next == st_wait_before_latch) ? wait_cnt + 5'd1 : 5'd0;

            if (next == st_idle)
            begin
                acknowledged             <= 1'b0;
                status.low_timeout_error <= 1'b0;
                status.assert_veto       <= !trigger_enable || (trigger_veto && !cfg.disable_veto);
                status.accept_error      <= trigger && trigger_enable;
            end
            else if (trigger_ack)
                acknowledged <= 1'b1;
        end
    end

    // TLU clock only while the number is clocked out, data mode only
    a_clock_enable_in_send: assert property (@(posedge TRIGGER_CLK) disable iff (!rst_n)
        status.clock_enable |-> (state == st_send_tlu_clock)
                                && (cfg.mode == mode_data_handshake)
                                && (tlu_clk_cnt != 9'd0) && (tlu_clk_cnt <= clk_target))
        else $error("clock_enable high outside the TLU clock window");

    // a trigger is only taken from idle
    a_accept_latch_apart: assert property (@(posedge TRIGGER_CLK) disable iff (!rst_n)
        accept_pulse |-> !latch_pulse && ($past(state) == st_idle))
        else $error("accept_pulse not from idle or together with latch_pulse");

endmodule

//--- design/tlu_data_receiver.sv
`timescale 1ns/100ps

module tlu_data_receiver (
    input  logic                           TRIGGER_CLK,
    input  logic                           rst_n,
    input  logic                           trigger,
    input  logic                           latch_pulse,
    input  tlu_pkg::tlu_config_t           cfg,
    output logic [tlu_pkg::data_width-1:0] trigger_number
);
    import tlu_pkg::*;

    logic [sr_width-1:0]   data_sr;      // newest sample in bit 0
    logic [5:0]            bit_count;    // number bits kept, first bit sent is dropped
    logic [data_width-1:0] number_next;

    assign bit_count = (cfg.clock_cycles == 5'd0) ? 6'd31 : ({1'b0, cfg.clock_cycles} - 6'd1);

    // oversampled serial stream, clk_divisor samples per bit
    always_ff @(posedge TRIGGER_CLK)
    begin
        data_sr <= {data_sr[sr_width-2:0], trigger};
    end

    // last bit sent sits in the lowest window, one sample per window
    always_comb
    begin
        number_next = '0;
        for (int n = 0; n < data_width - 1; n++)
        begin
            if (n < int'(bit_count))
            begin
                if (cfg.msb_first)
                    number_next[n] = data_sr[n * clk_divisor + clk_divisor - 1];
                else
                    number_next[n] = data_sr[(int'(bit_count) - 1 - n) * clk_divisor
                                             + clk_divisor - 1];
            end
        end
    end

    always_ff @(posedge TRIGGER_CLK or negedge rst_n)
    begin
        if (!rst_n)
            trigger_number <= '0;
        else if (latch_pulse)
            trigger_number <= number_next;  // upper bits stay zero
    end

    // number only moves on a latch
    a_number_stable: assert property (@(posedge TRIGGER_CLK) disable iff (!rst_n)
        !latch_pulse |=> $stable(trigger_number))
        else $error("trigger_number changed without latch_pulse");

endmodule

//--- design/tlu_fifo_formatter.sv
`timescale 1ns/100ps

module tlu_fifo_formatter (
    input  logic                           TRIGGER_CLK,
    input  logic                           rst_n,
    input  logic                           accept_pulse,
    input  logic                           latch_pulse,
    input  logic [tlu_pkg::data_width-1:0] trigger_number,
    input  logic [tlu_pkg::data_width-1:0] timestamp,
    input  tlu_pkg::tlu_mode_e             mode,
    output logic                           fifo_write,
    output tlu_pkg::fifo_word_t            fifo_data
);
    import tlu_pkg::*;

    logic [data_width-1:0] timestamp_q;  // timestamp closest to the trigger

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (accept_pulse)
            timestamp_q <= timestamp;
    end

    // one cycle after the latch, so the new number is already there
    always_ff @(posedge TRIGGER_CLK or negedge rst_n)
    begin
        if (!rst_n)
            fifo_write <= 1'b0;
        else
            fifo_write <= latch_pulse;
    end

    always_comb
    begin
        fifo_data.marker = 1'b1;
        if (mode == mode_data_handshake)
            fifo_data.payload = trigger_number[data_width-2:0];
        else
            fifo_data.payload = timestamp_q[data_width-2:0];  // timestamp in the other modes
    end

endmodule

//--- design/tlu_controller.sv
`timescale 1ns/100ps

module tlu_controller (
    input  logic                           TRIGGER_CLK,
    input  logic                           rst_n,
    input  logic                           trigger,          // TLU trigger line
    input  logic                           trigger_flag,
    input  logic                           trigger_veto,
    input  logic                           trigger_enable,
    input  logic                           trigger_ack,
    input  tlu_pkg::tlu_config_t           cfg,
    input  logic [tlu_pkg::data_width-1:0] timestamp,
    output logic                           fifo_write,
    output tlu_pkg::fifo_word_t            fifo_data,
    output logic                           trigger_accepted,
    output tlu_pkg::tlu_status_t           status
);
    import tlu_pkg::*;

    logic                  accept_pulse;
    logic                  latch_pulse;
    logic [data_width-1:0] trigger_number;

    assign trigger_accepted = accept_pulse;

    // control path, counters and status
    tlu_trigger_fsm u_tlu_trigger_fsm (
        .TRIGGER_CLK    (TRIGGER_CLK),
        .rst_n          (rst_n),
        .trigger        (trigger),
        .trigger_flag   (trigger_flag),
        .trigger_veto   (trigger_veto),
        .trigger_enable (trigger_enable),
        .trigger_ack    (trigger_ack),
        .cfg            (cfg),
        .accept_pulse   (accept_pulse),
        .latch_pulse    (latch_pulse),
        .status         (status)
    );

    // serial trigger number from the TLU
    tlu_data_receiver u_tlu_data_receiver (
        .TRIGGER_CLK    (TRIGGER_CLK),
        .rst_n          (rst_n),
        .trigger        (trigger),
        .latch_pulse    (latch_pulse),
        .cfg            (cfg),
        .trigger_number (trigger_number)
    );

    tlu_fifo_formatter u_tlu_fifo_formatter (
        .TRIGGER_CLK    (TRIGGER_CLK),
        .rst_n          (rst_n),
        .accept_pulse   (accept_pulse),
        .latch_pulse    (latch_pulse),
        .trigger_number (trigger_number),
        .timestamp      (timestamp),
        .mode           (cfg.mode),
        .fifo_write     (fifo_write),
        .fifo_data      (fifo_data)
    );

endmodule

//--- testbench/tb_tlu_tasks.svh
`ifndef TB_TLU_TASKS_SVH
`define TB_TLU_TASKS_SVH

    task automatic check_word(input string name, input fifo_word_t actual,
                              input fifo_word_t expected);
        if (actual !== expected)
        begin
            $display("** Error: %s expected 0x%h, got 0x%h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_status(input string name, input tlu_status_t actual,
                                input tlu_status_t expected);
        if (actual !== expected)
        begin
            $display("** Error: %s expected 0x%h, got 0x%h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("** Error: %s expected 0x%h, got 0x%h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_count(input string name, input int actual, input int expected);
        if (actual != expected)
        begin
            $display("** Error: %s expected 0x%h, got 0x%h", name, expected, actual);
            error_count++;
        end
    endtask

    function automatic tlu_status_t expected_status(input logic busy, input logic veto,
                                                    input logic timeout_err,
                                                    input logic accept_err);
        tlu_status_t s;
        s.busy              = busy;
        s.clock_enable      = 1'b0;
        s.assert_veto       = veto;
        s.low_timeout_error = timeout_err;
        s.accept_error      = accept_err;
        return s;
    endfunction

    task automatic note_timeout(input string what);
        $display("%s did not arrive within %0d cycles", what, timeout_cycles);
        error_count++;
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, error_count - errors_before);
    endtask

    // raise flag or line, new timestamp each cycle until the trigger is taken
    task automatic raise_trigger(input logic by_flag, input logic hold_line,
                                 output logic [data_width-1:0] ts_expected, output bit seen);
        int i;
        seen        = 1'b0;
        ts_expected = '0;
        @(negedge TRIGGER_CLK);
        trigger_flag = by_flag;
        trigger      = !by_flag;
        timestamp    = $urandom;
        for (i = 0; i < timeout_cycles && !seen; i++)
        begin
            @(negedge TRIGGER_CLK);
            timestamp = $urandom;
            if (trigger_accepted)
            begin
                seen         = 1'b1;
                ts_expected  = timestamp;  // captured at the end of the accept cycle
                trigger_flag = 1'b0;
                trigger      = hold_line;
            end
        end
        if (!seen)
            note_timeout("trigger_accepted");
    endtask

    task automatic wait_word(output fifo_word_t word, output int ce_cycles,
                             output int accepts, output bit seen);
        int i;
        word      = '0;
        ce_cycles = 0;
        accepts   = 0;
        seen      = 1'b0;
        for (i = 0; i < timeout_cycles && !seen; i++)
        begin
            @(negedge TRIGGER_CLK);
            if (status.clock_enable)
                ce_cycles++;
            if (trigger_accepted)
                accepts++;
            if (fifo_write)
            begin
                seen = 1'b1;
                word = fifo_data;
            end
            else
                timestamp = $urandom;  // late values must not reach the word
        end
        if (!seen)
            note_timeout("fifo_write");
    endtask

    // TLU side, one bit per clk_divisor cycles after data_delay
    task automatic send_tlu_number(input logic [data_width-1:0] number, input int nbits,
                                   input logic msb_first, input int delay);
        int  i;
        int  m;
        bit  seen;
        seen = 1'b0;
        for (i = 0; i < timeout_cycles && !seen; i++)
        begin
            @(negedge TRIGGER_CLK);
            seen = status.clock_enable;
        end
        if (!seen)
            note_timeout("clock_enable");
        else
        begin
            repeat (delay) @(negedge TRIGGER_CLK);
            for (m = 0; m < nbits; m++)
            begin
                if (m == 0)
                    trigger = 1'b1;  // leading bit, dropped by the receiver
                else if (msb_first)
                    trigger = number[nbits - 1 - m];
                else
                    trigger = number[m - 1];
                repeat (clk_divisor) @(negedge TRIGGER_CLK);
            end
            trigger = 1'b0;
        end
    endtask

    task automatic acknowledge(input logic accept_err);
        trigger_ack = 1'b1;
        @(negedge TRIGGER_CLK);
        check_bit("busy", status.busy, 1'b0);
        check_bit("accept_error", status.accept_error, accept_err);
        check_bit("fifo_write", fifo_write, 1'b0);  // one word per trigger
        trigger      = 1'b0;
        trigger_flag = 1'b0;
        @(negedge TRIGGER_CLK);
        trigger_ack = 1'b0;
        @(negedge TRIGGER_CLK);
    endtask

    task automatic reset_values();
        int errors_before;
        errors_before = error_count;
        repeat (2) @(negedge TRIGGER_CLK);
        check_status("status", status, expected_status(1'b0, 1'b0, 1'b0, 1'b0));
        check_bit("fifo_write", fifo_write, 1'b0);
        check_bit("trigger_accepted", trigger_accepted, 1'b0);
        report_test("reset", errors_before);
    endtask

    task automatic no_handshake_word();
        int                    errors_before;
        logic [data_width-1:0] ts_expected;
        fifo_word_t            word;
        fifo_word_t            expected;
        int                    ce_cycles;
        int                    accepts;
        bit                    seen;
        errors_before = error_count;
        cfg           = '0;
        cfg.mode      = mode_no_handshake;
        raise_trigger(1'b1, 1'b0, ts_expected, seen);
        wait_word(word, ce_cycles, accepts, seen);
        check_status("status", status, expected_status(1'b1, 1'b0, 1'b0, 1'b0));
        expected.marker  = 1'b1;
        expected.payload = ts_expected[data_width-2:0];
        check_word("fifo_data", word, expected);
        check_count("trigger_accepted pulses", accepts + 1, 1);
        check_count("clock_enable cycles", ce_cycles, 0);
        acknowledge(1'b0);
        report_test("no_handshake", errors_before);
    endtask

    task automatic run_data_trigger(input logic [4:0] clock_cycles, input logic msb_first,
                                    input logic [3:0] delay, input logic [data_width-1:0] number);
        logic [data_width-1:0] ts_unused;
        fifo_word_t            word;
        fifo_word_t            expected;
        int                    nbits;
        int                    ce_cycles;
        int                    accepts;
        bit                    seen;
        bit                    word_seen;
        nbits            = (clock_cycles == 5'd0) ? 32 : int'(clock_cycles);
        cfg              = '0;
        cfg.mode         = mode_data_handshake;
        cfg.clock_cycles = clock_cycles;
        cfg.msb_first    = msb_first;
        cfg.data_delay   = delay;
        raise_trigger(1'b0, 1'b0, ts_unused, seen);
        fork
            send_tlu_number(number, nbits, msb_first, int'(delay));
            wait_word(word, ce_cycles, accepts, word_seen);
        join
        check_status("status", status, expected_status(1'b1, 1'b0, 1'b0, 1'b0));
        check_count("clock_enable cycles", ce_cycles, nbits * clk_divisor);
        expected.marker  = 1'b1;
        expected.payload = number[data_width-2:0];  // upper bits of number are zero
        check_word("fifo_data", word, expected);
        acknowledge(1'b0);
    endtask

    task automatic data_default_length();
        int errors_before;
        errors_before = error_count;
        run_data_trigger(5'd0, 1'b0, 4'd2, $urandom & 32'h7fff_ffff);
        report_test("data_handshake 32 bits", errors_before);
    endtask

    task automatic data_short_msb_first();
        int errors_before;
        errors_before = error_count;
        run_data_trigger(5'd16, 1'b1, 4'd5, $urandom & 32'h0000_7fff);
        report_test("data_handshake 16 bits msb first", errors_before);
    endtask

    task automatic timeout_and_veto();
        int                    errors_before;
        logic [data_width-1:0] ts_expected;
        fifo_word_t            word;
        fifo_word_t            expected;
        int                    ce_cycles;
        int                    accepts;
        bit                    seen;
        errors_before   = error_count;
        cfg             = '0;
        cfg.mode        = mode_simple_handshake;
        cfg.low_timeout = 8'd20;
        raise_trigger(1'b0, 1'b1, ts_expected, seen);  // line stays high
        repeat (19) @(negedge TRIGGER_CLK);
        check_bit("low_timeout_error", status.low_timeout_error, 1'b0);
        @(negedge TRIGGER_CLK);
        check_bit("low_timeout_error", status.low_timeout_error, 1'b1);
        wait_word(word, ce_cycles, accepts, seen);
        check_status("status", status, expected_status(1'b1, 1'b0, 1'b1, 1'b0));
        expected.marker  = 1'b1;
        expected.payload = ts_expected[data_width-2:0];
        check_word("fifo_data", word, expected);
        acknowledge(1'b1);  // trigger still high back in idle
        trigger_enable = 1'b0;
        @(negedge TRIGGER_CLK);
        check_status("status", status, expected_status(1'b0, 1'b1, 1'b0, 1'b0));
        trigger_enable = 1'b1;
        trigger_veto   = 1'b1;
        @(negedge TRIGGER_CLK);
        check_bit("assert_veto", status.assert_veto, 1'b1);
        cfg.disable_veto = 1'b1;
        @(negedge TRIGGER_CLK);
        check_bit("assert_veto", status.assert_veto, 1'b0);
        trigger_veto     = 1'b0;
        cfg.disable_veto = 1'b0;
        @(negedge TRIGGER_CLK);
        report_test("timeout and veto", errors_before);
    endtask

`endif

//--- testbench/tb_tlu_controller.sv
`timescale 1ns/100ps

module tb_tlu_controller;
    import tlu_pkg::*;

    localparam int timeout_cycles = 2000;  // longest trigger takes about 300 cycles

    logic                  TRIGGER_CLK;
    logic                  rst_n;
    logic                  trigger;
    logic                  trigger_flag;
    logic                  trigger_veto;
    logic                  trigger_enable;
    logic                  trigger_ack;
    tlu_config_t           cfg;
    logic [data_width-1:0] timestamp;
    logic                  fifo_write;
    fifo_word_t            fifo_data;
    logic                  trigger_accepted;
    tlu_status_t           status;

    int error_count;
    int test_count;
    int seed;

    tlu_controller u_tlu_controller (
        .TRIGGER_CLK      (TRIGGER_CLK),
        .rst_n            (rst_n),
        .trigger          (trigger),
        .trigger_flag     (trigger_flag),
        .trigger_veto     (trigger_veto),
        .trigger_enable   (trigger_enable),
        .trigger_ack      (trigger_ack),
        .cfg              (cfg),
        .timestamp        (timestamp),
        .fifo_write       (fifo_write),
        .fifo_data        (fifo_data),
        .trigger_accepted (trigger_accepted),
        .status           (status)
    );

    // 40 ns period
    always #20 TRIGGER_CLK = ~TRIGGER_CLK;

    `include "tb_tlu_tasks.svh"

    initial
    begin
        TRIGGER_CLK    = 1'b0;
        rst_n          = 1'b0;
        trigger        = 1'b0;
        trigger_flag   = 1'b0;
        trigger_veto   = 1'b0;
        trigger_enable = 1'b1;  // enabled, so no veto once out of reset
        trigger_ack    = 1'b0;
        cfg            = '0;
        cfg.mode       = mode_no_handshake;
        timestamp      = '0;
        error_count    = 0;
        test_count     = 0;
        seed           = 90168;
        void'($urandom(seed));

        repeat (4) @(posedge TRIGGER_CLK);
        @(negedge TRIGGER_CLK);
        rst_n = 1'b1;

        reset_values();
        no_handshake_word();
        data_default_length();
        data_short_msb_first();
        timeout_and_veto();

        $display("tests run: %0d, errors: %0d", test_count, error_count);
        if (error_count == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

//--- tlu_controller.f
+incdir+testbench
design/tlu_pkg.sv
design/tlu_trigger_fsm.sv
design/tlu_data_receiver.sv
design/tlu_fifo_formatter.sv
design/tlu_controller.sv
testbench/tb_tlu_controller.sv
